/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_shield
FILELIST  ?= tb.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and search for the pass message"
	@echo "  clean  remove the obj_dir build folder"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* design/adc_sampler.sv */
`timescale 1ns/1ps

module adc_sampler (
  input  logic                            i_clk,
  input  logic                            i_arst_n,

  output logic                            o_adc_convst,
  output logic                            o_adc_sck,
  output logic                            o_adc_sdi,
  input  logic                            i_adc_sdo,

  output logic                            o_sample_valid,
  output logic [shield_pkg::ADC_CH_W-1:0] o_sample_ch,
  output logic [shield_pkg::ADC_BITS-1:0] o_sample_value
);
  import shield_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_CONV, ST_WAIT, ST_SHIFT} state_t;

  state_t                  state;
  logic [ADC_CNT_W-1:0]    cnt;
  logic [ADC_BIT_W-1:0]    bit_cnt;
  logic [ADC_CH_W-1:0]     cfg_ch;  // Channel configured in the current frame.
  logic [ADC_CH_W-1:0]     res_ch;  // Channel whose result is shifted out now.
  logic [ADC_CH_W-1:0]     nxt_ch;
  logic                    primed;
  logic [ADC_CFG_BITS-1:0] cfg_sr;
  logic [ADC_BITS-1:0]     sdo_sr;
  logic                    sck_rise;
  logic                    sck_fall;
  logic                    last_bit;

  // LTC2308 word for a single ended unipolar input with sleep off.
  function automatic logic [ADC_CFG_BITS-1:0] cfg_word(input logic [ADC_CH_W-1:0] ch);
    logic [2:0] ch3;
    ch3 = 3'(ch);
    return {1'b1, ch3[0], ch3[2:1], 1'b1, 1'b0};
  endfunction

  assign nxt_ch   = (cfg_ch == ADC_CH_W'(ADC_CHANNELS - 1)) ? '0 : cfg_ch + 1'b1;
  assign sck_rise = (state == ST_SHIFT) && (cnt == ADC_CNT_W'(ADC_SCK_DIV - 1)) && !o_adc_sck;
  assign sck_fall = (state == ST_SHIFT) && (cnt == ADC_CNT_W'(ADC_SCK_DIV - 1)) && o_adc_sck;
  assign last_bit = (bit_cnt == ADC_BIT_W'(ADC_BITS - 1));

  assign o_adc_convst = (state == ST_CONV);
  assign o_adc_sdi    = cfg_sr[ADC_CFG_BITS-1];  // MSB first.

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state          <= ST_IDLE;
      cnt            <= '0;
      bit_cnt        <= '0;
      cfg_ch         <= ADC_CH_W'(ADC_CHANNELS - 1);
      res_ch         <= '0;
      primed         <= 1'b0;
      cfg_sr         <= '0;
      o_adc_sck      <= 1'b0;
      o_sample_valid <= 1'b0;
    end else begin
      o_sample_valid <= 1'b0;
      case (state)
        ST_IDLE: state <= ST_CONV;
        ST_CONV: begin
          res_ch <= cfg_ch;
          cfg_ch <= nxt_ch;
          cfg_sr <= cfg_word(nxt_ch);
          cnt    <= '0;
          state  <= ST_WAIT;
        end
        ST_WAIT: begin
          if (cnt == ADC_CNT_W'(ADC_CONV_CYCLES - 1)) begin
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= ST_SHIFT;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_SHIFT: begin
          if (sck_rise || sck_fall) begin
            cnt       <= '0;
            o_adc_sck <= ~o_adc_sck;
          end else begin
            cnt <= cnt + 1'b1;
          end
          if (sck_fall) begin
            cfg_sr  <= cfg_sr << 1;
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              state          <= ST_CONV;
              primed         <= 1'b1;
              o_sample_valid <= primed;  // First frame has no configured result.
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (sck_rise) begin
      sdo_sr <= {sdo_sr[ADC_BITS-2:0], i_adc_sdo};
    end
    if (sck_fall && last_bit) begin
      o_sample_ch    <= res_ch;
      o_sample_value <= sdo_sr;
    end
  end

  a_sck_idle_low: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (state != ST_SHIFT) |-> !o_adc_sck
  );

endmodule

/* design/bus_node.sv */
`timescale 1ns/1ps

module bus_node #(
  parameter logic [shield_pkg::BUS_AW-1:0] ADDR_BASE = '0,
  parameter int                            SIZE      = shield_pkg::WIN_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_arst_n,

  input  logic                          i_bus_req,
  input  logic                          i_bus_ack,
  input  logic                          i_bus_write,
  input  logic [shield_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [shield_pkg::BUS_DW-1:0] i_bus_data,

  output logic                          o_bus_req,
  output logic                          o_bus_ack,
  output logic                          o_bus_write,
  output logic [shield_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [shield_pkg::BUS_DW-1:0] o_bus_data,

  output logic                          o_reg_wr,
  output logic                          o_reg_rd,
  output logic [SIZE-1:0]               o_reg_offset,
  output logic [shield_pkg::BUS_DW-1:0] o_reg_wdata,
  input  logic [shield_pkg::BUS_DW-1:0] i_reg_rdata
);
  import shield_pkg::*;

  logic hit;
  logic claim;

  // Only the bits above the window are decoded.
  assign hit   = (i_bus_addr[BUS_AW-1:SIZE] == ADDR_BASE[BUS_AW-1:SIZE]);
  assign claim = i_bus_req & ~i_bus_ack & hit;  // First matching node wins.

  assign o_reg_wr     = claim & i_bus_write;
  assign o_reg_rd     = claim & ~i_bus_write;
  assign o_reg_offset = i_bus_addr[SIZE-1:0];
  assign o_reg_wdata  = i_bus_data;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bus_req <= 1'b0;
      o_bus_ack <= 1'b0;
    end else begin
      o_bus_req <= i_bus_req;
      o_bus_ack <= i_bus_ack | claim;
    end
  end

  always_ff @(posedge i_clk) begin
    o_bus_write <= i_bus_write;
    o_bus_addr  <= i_bus_addr;
    // Read data replaces the request payload.
    o_bus_data  <= o_reg_rd ? i_reg_rdata : i_bus_data;
  end

  // Upstream must never hand over an ack without a request.
  a_ack_needs_req: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_bus_ack |-> o_bus_req
  );

endmodule

/* design/joystick.sv */
`timescale 1ns/1ps

module joystick #(
  parameter logic [shield_pkg::BUS_AW-1:0] ADDR_BASE = shield_pkg::JOY_BASE,
  parameter int                            SIZE      = shield_pkg::WIN_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_arst_n,

  output logic                          o_adc_convst,
  output logic                          o_adc_sck,
  output logic                          o_adc_sdi,
  input  logic                          i_adc_sdo,

  input  logic                          i_bus_req,
  input  logic                          i_bus_ack,
  input  logic                          i_bus_write,
  input  logic [shield_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [shield_pkg::BUS_DW-1:0] i_bus_data,

  output logic                          o_bus_req,
  output logic                          o_bus_ack,
  output logic                          o_bus_write,
  output logic [shield_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [shield_pkg::BUS_DW-1:0] o_bus_data
);
  import shield_pkg::*;

  logic [SIZE-1:0]     reg_offset;
  logic [BUS_DW-1:0]   reg_rdata;
  logic                sample_valid;
  logic [ADC_CH_W-1:0] sample_ch;
  logic [ADC_BITS-1:0] sample_value;
  logic [ADC_BITS-1:0] joy_x;
  logic [ADC_BITS-1:0] joy_y;
  logic [31:0]         sample_count;

  bus_node #(.ADDR_BASE(ADDR_BASE), .SIZE(SIZE)) u_node (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_bus_req    (i_bus_req),
    .i_bus_ack    (i_bus_ack),
    .i_bus_write  (i_bus_write),
    .i_bus_addr   (i_bus_addr),
    .i_bus_data   (i_bus_data),
    .o_bus_req    (o_bus_req),
    .o_bus_ack    (o_bus_ack),
    .o_bus_write  (o_bus_write),
    .o_bus_addr   (o_bus_addr),
    .o_bus_data   (o_bus_data),
    .o_reg_wr     (),            // Read-only registers.
    .o_reg_rd     (),
    .o_reg_offset (reg_offset),
    .o_reg_wdata  (),
    .i_reg_rdata  (reg_rdata)
  );

  adc_sampler u_adc (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .o_adc_convst   (o_adc_convst),
    .o_adc_sck      (o_adc_sck),
    .o_adc_sdi      (o_adc_sdi),
    .i_adc_sdo      (i_adc_sdo),
    .o_sample_valid (sample_valid),
    .o_sample_ch    (sample_ch),
    .o_sample_value (sample_value)
  );

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      joy_x        <= '0;
      joy_y        <= '0;
      sample_count <= '0;
    end else if (sample_valid) begin
      if (sample_ch == ADC_CH_W'(0)) joy_x <= sample_value;
      if (sample_ch == ADC_CH_W'(1)) joy_y <= sample_value;
      sample_count <= sample_count + 1'b1;
    end
  end

  always_comb begin
    case (reg_offset)
      SIZE'(JOY_REG_X):     reg_rdata = BUS_DW'(joy_x);
      SIZE'(JOY_REG_Y):     reg_rdata = BUS_DW'(joy_y);
      SIZE'(JOY_REG_COUNT): reg_rdata = BUS_DW'(sample_count);
      default:              reg_rdata = '0;
    endcase
  end

endmodule

/* design/shield.sv */
`timescale 1ns/1ps

module shield (
  input  logic                          i_clk,
  input  logic                          i_arst_n,

  input  logic                          i_bus_req,
  input  logic                          i_bus_ack,
  input  logic                          i_bus_write,
  input  logic [shield_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [shield_pkg::BUS_DW-1:0] i_bus_data,

  output logic                          o_bus_req,
  output logic                          o_bus_ack,
  output logic                          o_bus_write,
  output logic [shield_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [shield_pkg::BUS_DW-1:0] o_bus_data,

  output logic                          o_adc_convst,
  output logic                          o_adc_sck,
  output logic                          o_adc_sdi,
  input  logic                          i_adc_sdo,

  output logic [15:0]                   o_arduino_io
);
  import shield_pkg::*;

  // Ring segment from joystick to display.
  logic              jd_bus_req;
  logic              jd_bus_ack;
  logic              jd_bus_write;
  logic [BUS_AW-1:0] jd_bus_addr;
  logic [BUS_DW-1:0] jd_bus_data;

  logic tft_dc;
  logic tft_cs;
  logic tft_mosi;
  logic tft_sck;

  joystick #(.ADDR_BASE(JOY_BASE), .SIZE(WIN_SIZE)) u_joystick (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .o_adc_convst (o_adc_convst), .o_adc_sck (o_adc_sck),
    .o_adc_sdi (o_adc_sdi), .i_adc_sdo (i_adc_sdo),
    .i_bus_req (i_bus_req), .i_bus_ack (i_bus_ack), .i_bus_write (i_bus_write),
    .i_bus_addr (i_bus_addr), .i_bus_data (i_bus_data),
    .o_bus_req (jd_bus_req), .o_bus_ack (jd_bus_ack), .o_bus_write (jd_bus_write),
    .o_bus_addr (jd_bus_addr), .o_bus_data (jd_bus_data)
  );

  st7735r #(.ADDR_BASE(DISP_BASE), .SIZE(WIN_SIZE)) u_display (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .o_tft_dc (tft_dc), .o_tft_sck (tft_sck), .o_tft_mosi (tft_mosi), .o_tft_cs (tft_cs),
    .i_bus_req (jd_bus_req), .i_bus_ack (jd_bus_ack), .i_bus_write (jd_bus_write),
    .i_bus_addr (jd_bus_addr), .i_bus_data (jd_bus_data),
    .o_bus_req (o_bus_req), .o_bus_ack (o_bus_ack), .o_bus_write (o_bus_write),
    .o_bus_addr (o_bus_addr), .o_bus_data (o_bus_data)
  );

  // Shield header. SD card, MISO and spare pins held low.
  always_comb begin
    o_arduino_io     = '0;
    o_arduino_io[8]  = tft_dc;
    o_arduino_io[10] = tft_cs;
    o_arduino_io[11] = tft_mosi;
    o_arduino_io[13] = tft_sck;
  end

endmodule

/* design/shield_pkg.sv */
package shield_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ring bus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;

  localparam logic [BUS_AW-1:0] JOY_BASE  = 32'hC100_0100;
  localparam logic [BUS_AW-1:0] DISP_BASE = 32'hC200_0000;
  localparam int WIN_SIZE = 5;  // 32 word offsets per window.

  localparam int JOY_REG_X     = 0;
  localparam int JOY_REG_Y     = 1;
  localparam int JOY_REG_COUNT = 2;

  localparam int DISP_REG_CMD    = 0;
  localparam int DISP_REG_DATA   = 1;
  localparam int DISP_REG_STATUS = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Joystick ADC.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ADC_BITS        = 12;
  localparam int ADC_CHANNELS    = 2;
  localparam int ADC_SCK_DIV     = 2;
  localparam int ADC_CONV_CYCLES = 80;  // 1.6 us at 50 MHz.
  localparam int ADC_CFG_BITS    = 6;
  localparam int ADC_CH_W        = (ADC_CHANNELS > 1) ? $clog2(ADC_CHANNELS) : 1;
  localparam int ADC_CNT_W       = $clog2(ADC_CONV_CYCLES + 1);
  localparam int ADC_BIT_W       = $clog2(ADC_BITS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Display.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SPI_SCK_DIV     = 2;
  localparam int SPI_DIV_W       = $clog2(SPI_SCK_DIV + 1);
  localparam int DISP_FIFO_DEPTH = 8;
  localparam int DISP_FIFO_AW    = $clog2(DISP_FIFO_DEPTH);

endpackage

/* design/spi_tx.sv */
`timescale 1ns/1ps

module spi_tx (
  input  logic       i_clk,
  input  logic       i_arst_n,

  input  logic       i_start,
  input  logic [7:0] i_byte,
  input  logic       i_dc,
  output logic       o_busy,

  output logic       o_sck,
  output logic       o_mosi,
  output logic       o_cs,
  output logic       o_dc
);
  import shield_pkg::*;

  logic [SPI_DIV_W-1:0] div;
  logic [2:0]           bit_cnt;
  logic [7:0]           shift_sr;
  logic                 shifting;
  logic                 half_done;

  // Busy with CS high is the one-cycle gap after a byte.
  assign shifting  = o_busy & ~o_cs;
  assign half_done = (div == SPI_DIV_W'(SPI_SCK_DIV - 1));
  assign o_mosi    = shift_sr[7];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_busy   <= 1'b0;
      o_cs     <= 1'b1;
      o_sck    <= 1'b0;
      o_dc     <= 1'b0;
      div      <= '0;
      bit_cnt  <= '0;
      shift_sr <= '0;
    end else if (i_start && !o_busy) begin
      o_busy   <= 1'b1;
      o_cs     <= 1'b0;
      o_dc     <= i_dc;
      div      <= '0;
      bit_cnt  <= '0;
      shift_sr <= i_byte;
    end else if (shifting) begin
      if (!half_done) begin
        div <= div + 1'b1;
      end else begin
        div   <= '0;
        o_sck <= ~o_sck;
        if (o_sck) begin  // Falling edge moves on to the next bit.
          shift_sr <= {shift_sr[6:0], 1'b0};
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) o_cs <= 1'b1;
        end
      end
    end else if (o_busy) begin
      o_busy <= 1'b0;
    end
  end

  // The FIFO side must wait for the shifter.
  a_no_start_busy: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    !(i_start && o_busy)
  );

endmodule

/* design/st7735r.sv */
`timescale 1ns/1ps

module st7735r #(
  parameter logic [shield_pkg::BUS_AW-1:0] ADDR_BASE = shield_pkg::DISP_BASE,
  parameter int                            SIZE      = shield_pkg::WIN_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_arst_n,

  output logic                          o_tft_dc,
  output logic                          o_tft_sck,
  output logic                          o_tft_mosi,
  output logic                          o_tft_cs,

  input  logic                          i_bus_req,
  input  logic                          i_bus_ack,
  input  logic                          i_bus_write,
  input  logic [shield_pkg::BUS_AW-1:0] i_bus_addr,
  input  logic [shield_pkg::BUS_DW-1:0] i_bus_data,

  output logic                          o_bus_req,
  output logic                          o_bus_ack,
  output logic                          o_bus_write,
  output logic [shield_pkg::BUS_AW-1:0] o_bus_addr,
  output logic [shield_pkg::BUS_DW-1:0] o_bus_data
);
  import shield_pkg::*;

  logic                    reg_wr;
  logic                    reg_rd;
  logic [SIZE-1:0]         reg_offset;
  logic [BUS_DW-1:0]       reg_wdata;
  logic [BUS_DW-1:0]       reg_rdata;
  logic [8:0]              fifo_mem [DISP_FIFO_DEPTH];  // {dc, byte}.
  logic [DISP_FIFO_AW-1:0] wr_ptr;
  logic [DISP_FIFO_AW-1:0] rd_ptr;
  logic [DISP_FIFO_AW:0]   level;
  logic                    overflow;
  logic                    push;
  logic                    accept;
  logic                    pop;
  logic                    spi_busy;

  bus_node #(.ADDR_BASE(ADDR_BASE), .SIZE(SIZE)) u_node (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_bus_req (i_bus_req), .i_bus_ack (i_bus_ack), .i_bus_write (i_bus_write),
    .i_bus_addr (i_bus_addr), .i_bus_data (i_bus_data),
    .o_bus_req (o_bus_req), .o_bus_ack (o_bus_ack), .o_bus_write (o_bus_write),
    .o_bus_addr (o_bus_addr), .o_bus_data (o_bus_data),
    .o_reg_wr (reg_wr), .o_reg_rd (reg_rd), .o_reg_offset (reg_offset),
    .o_reg_wdata (reg_wdata), .i_reg_rdata (reg_rdata)
  );

  assign push   = reg_wr && (reg_offset == SIZE'(DISP_REG_CMD) ||
                             reg_offset == SIZE'(DISP_REG_DATA));
  assign accept = push && (level != (DISP_FIFO_AW + 1)'(DISP_FIFO_DEPTH));
  assign pop    = (level != '0) && !spi_busy;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end else begin
      if (accept) wr_ptr <= (wr_ptr == DISP_FIFO_AW'(DISP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == DISP_FIFO_AW'(DISP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (accept && !pop) level <= level + 1'b1;
      else if (pop && !accept) level <= level - 1'b1;
      if (push && !accept) overflow <= 1'b1;  // Sticky.
      else if (reg_rd && reg_offset == SIZE'(DISP_REG_STATUS)) overflow <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) fifo_mem[wr_ptr] <= {reg_offset == SIZE'(DISP_REG_DATA), reg_wdata[7:0]};
  end

  always_comb begin
    reg_rdata = '0;
    if (reg_offset == SIZE'(DISP_REG_STATUS)) begin
      reg_rdata[DISP_FIFO_AW:0] = level;
      reg_rdata[8]              = spi_busy;
      reg_rdata[16]             = overflow;
    end
  end

  spi_tx u_spi (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_start (pop), .i_byte (fifo_mem[rd_ptr][7:0]), .i_dc (fifo_mem[rd_ptr][8]),
    .o_busy (spi_busy),
    .o_sck (o_tft_sck), .o_mosi (o_tft_mosi), .o_cs (o_tft_cs), .o_dc (o_tft_dc)
  );

endmodule

/* sim/tb_models.sv */
`timescale 1ns/1ps

// LTC2308 responder. A conversion result belongs to the channel configured
// in the frame before.
module adc_model (
  input  logic                                                   i_convst,
  input  logic                                                   i_sck,
  input  logic                                                   i_sdi,
  output logic                                                   o_sdo,
  input  logic [shield_pkg::ADC_CHANNELS*shield_pkg::ADC_BITS-1:0] i_values
);
  import shield_pkg::*;

  logic [ADC_BITS-1:0] sdi_sr;             // SDI bits of the last frame.
  logic [ADC_BITS-1:0] result     = '0;
  logic [2:0]          cfg_ch     = '0;
  logic                configured = 1'b0;
  int                  bit_idx    = 0;
  logic                sdo_q      = 1'b0;

  assign o_sdo = sdo_q;

  // SCK idles low while CONVST is high, so the levels tell which edge fired.
  always @(posedge i_convst or posedge i_sck or negedge i_sck) begin
    if (i_convst) begin
      // Word is S/D, O/S, S1, S0, UNI, SLP with the first bit in sdi_sr[11].
      if (configured) cfg_ch = {sdi_sr[ADC_BITS-3], sdi_sr[ADC_BITS-4], sdi_sr[ADC_BITS-2]};
      result     = (int'(cfg_ch) < ADC_CHANNELS) ?
                   i_values[int'(cfg_ch)*ADC_BITS +: ADC_BITS] : '0;
      configured = 1'b1;
      bit_idx    = ADC_BITS - 1;
      sdo_q     <= result[ADC_BITS-1];  // MSB is out once the conversion ends.
    end else if (i_sck) begin
      sdi_sr = {sdi_sr[ADC_BITS-2:0], i_sdi};
    end else begin
      bit_idx = bit_idx - 1;
      if (bit_idx >= 0) sdo_q <= result[bit_idx];
    end
  end

endmodule

// Display bus capture of {dc, byte} per completed byte.
module spi_monitor (
  input  logic i_sck,
  input  logic i_cs,
  input  logic i_mosi,
  input  logic i_dc
);
  logic [8:0] rx_q[$];
  logic [7:0] shift_sr = '0;
  int         n_bits   = 0;

  always @(posedge i_sck) begin
    if (!i_cs) begin
      shift_sr = {shift_sr[6:0], i_mosi};
      n_bits++;
      if (n_bits == 8) begin
        rx_q.push_back({i_dc, shift_sr});
        n_bits = 0;
      end
    end
  end

endmodule

/* sim/tb_shield.sv */
`timescale 1ns/1ps

module tb_shield;
  import shield_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RING_LAT     = 2;
  localparam int FRAME_CYCLES = 2 + ADC_CONV_CYCLES + 2 * ADC_SCK_DIV * ADC_BITS;
  localparam int BYTE_CYCLES  = 2 + 16 * SPI_SCK_DIV;
  localparam int N_UNMAPPED   = 20;
  localparam int N_DISP       = 16;
  localparam int N_BURST      = DISP_FIFO_DEPTH + 4;
  localparam int MAX_POLLS    = (DISP_FIFO_DEPTH + 2) * BYTE_CYCLES;
  // Twelve ADC frames and every display byte twice over plus slack.
  localparam int WATCHDOG_CYCLES = 12 * FRAME_CYCLES + 2 * (N_DISP + N_BURST) * BYTE_CYCLES
                                   + 2000;

  logic              clk;
  logic              arst_n;
  logic              bus_req;
  logic              bus_ack;
  logic              bus_write;
  logic [BUS_AW-1:0] bus_addr;
  logic [BUS_DW-1:0] bus_data;
  logic              ret_req;
  logic              ret_ack;
  logic              ret_write;
  logic [BUS_AW-1:0] ret_addr;
  logic [BUS_DW-1:0] ret_data;
  logic              adc_convst;
  logic              adc_sck;
  logic              adc_sdi;
  logic              adc_sdo;
  logic [15:0]       io;

  logic [ADC_CHANNELS*ADC_BITS-1:0] adc_vals;
  logic [31:0] rng_state = 32'd76280;
  int          n_checks  = 0;
  int          n_errors  = 0;
  int          cyc       = 0;

  // Issued and returned ring requests with the oldest first.
  logic        iss_write_q[$];
  logic [31:0] iss_addr_q[$];
  int          iss_cyc_q[$];
  logic        ret_ack_q[$];
  logic        ret_write_q[$];
  logic [31:0] ret_addr_q[$];
  logic [31:0] ret_data_q[$];
  int          ret_cyc_q[$];
  logic [8:0]  exp_spi[$];

  shield u_shield (
    .i_clk (clk), .i_arst_n (arst_n),
    .i_bus_req (bus_req), .i_bus_ack (bus_ack), .i_bus_write (bus_write),
    .i_bus_addr (bus_addr), .i_bus_data (bus_data),
    .o_bus_req (ret_req), .o_bus_ack (ret_ack), .o_bus_write (ret_write),
    .o_bus_addr (ret_addr), .o_bus_data (ret_data),
    .o_adc_convst (adc_convst), .o_adc_sck (adc_sck),
    .o_adc_sdi (adc_sdi), .i_adc_sdo (adc_sdo),
    .o_arduino_io (io)
  );

  adc_model u_adc_model (
    .i_convst (adc_convst), .i_sck (adc_sck), .i_sdi (adc_sdi), .o_sdo (adc_sdo),
    .i_values (adc_vals)
  );

  // Decoding from the header pins also shows that they carry the TFT signals.
  spi_monitor u_spi_mon (.i_sck (io[13]), .i_cs (io[10]), .i_mosi (io[11]), .i_dc (io[8]));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    hi        = rng_state[31:16];
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {hi, rng_state[31:16]};  // Upper halves only.
  endfunction

  function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base);
    return addr[31:WIN_SIZE] == base[31:WIN_SIZE];
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic new_adc_values();
    logic [31:0] r;
    for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
      r = rand32();
      adc_vals[ch*ADC_BITS +: ADC_BITS] <= r[ADC_BITS-1:0];
    end
  endtask

  task automatic wait_frames(input int n);
    repeat (n) @(posedge adc_convst);
  endtask

  task automatic send(input logic w, input logic [31:0] a, input logic [31:0] d);
    @(posedge clk);
    bus_req   <= 1'b1;
    bus_write <= w;
    bus_addr  <= a;
    bus_data  <= d;
    iss_write_q.push_back(w);
    iss_addr_q.push_back(a);
    iss_cyc_q.push_back(cyc);
  endtask

  task automatic release_bus();
    @(posedge clk);
    bus_req <= 1'b0;
  endtask

  task automatic receive(output logic ack, output logic [31:0] data);
    int waited;
    waited = 0;
    ack    = 1'b0;
    data   = '0;
    while (ret_cyc_q.size() == 0 && waited < 4 * RING_LAT + 4) begin
      @(negedge clk);
      waited++;
    end
    if (ret_cyc_q.size() == 0) begin
      n_errors++;
      $display("No ring response came back for address %h", iss_addr_q.pop_front());
      void'(iss_write_q.pop_front());
      void'(iss_cyc_q.pop_front());
    end else begin
      check("ring latency", RING_LAT, ret_cyc_q.pop_front() - iss_cyc_q.pop_front());
      check("ring write", iss_write_q.pop_front(), ret_write_q.pop_front());
      check("ring addr", iss_addr_q.pop_front(), ret_addr_q.pop_front());
      ack  = ret_ack_q.pop_front();
      data = ret_data_q.pop_front();
    end
  endtask

  task automatic access(input logic w, input logic [31:0] a, input logic [31:0] d,
                        output logic ack, output logic [31:0] data);
    send(w, a, d);
    release_bus();
    receive(ack, data);
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
    logic        ack;
    logic [31:0] data;
    access(1'b1, a, d, ack, data);
    check("write ack", 1, ack);
    check("write data", d, data);
  endtask

  task automatic read_reg(input logic [31:0] a, output logic [31:0] data);
    logic ack;
    access(1'b0, a, rand32(), ack, data);  // Random payload must be replaced.
    check("read ack", 1, ack);
  endtask

  // Polls STATUS until the queue is empty and the shifter idle.
  task automatic drain_display(output logic [31:0] status);
    int polls;
    polls = 0;
    read_reg(DISP_BASE + DISP_REG_STATUS, status);
    while (status[8:0] != '0 && polls < MAX_POLLS) begin
      read_reg(DISP_BASE + DISP_REG_STATUS, status);
      polls++;
    end
    if (status[8:0] != '0) begin
      n_errors++;
      $display("Display queue did not drain, status %h", status);
    end
  endtask

  task automatic compare_spi();
    int n;
    check("spi byte count", exp_spi.size(), u_spi_mon.rx_q.size());
    n = (exp_spi.size() < u_spi_mon.rx_q.size()) ? exp_spi.size() : u_spi_mon.rx_q.size();
    for (int i = 0; i < n; i++) check("spi dc and byte", exp_spi[i], u_spi_mon.rx_q[i]);
  endtask

  // Return path sampled mid-cycle. The cycle count lives here too.
  always @(negedge clk) begin
    if (arst_n && ret_req) begin
      ret_ack_q.push_back(ret_ack);
      ret_write_q.push_back(ret_write);
      ret_addr_q.push_back(ret_addr);
      ret_data_q.push_back(ret_data);
      ret_cyc_q.push_back(cyc);
    end
    cyc++;
  end

  always @(negedge clk) begin
    if (arst_n) check("unused header pins", 16'h0, io & ~16'h2D00);
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic        ack;
    logic        w;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] data;
    logic [31:0] cnt0;
    logic [31:0] cnt1;
    logic [31:0] status;
    arst_n    <= 1'b0;
    bus_req   <= 1'b0;
    bus_ack   <= 1'b0;
    bus_write <= 1'b0;
    bus_addr  <= '0;
    bus_data  <= '0;
    new_adc_values();
    @(posedge clk);
    @(negedge clk);
    check("reset req", 0, ret_req);
    check("reset ack", 0, ret_ack);
    check("reset convst", 0, adc_convst);
    check("reset tft cs", 1, io[10]);
    check("reset tft sck", 0, io[13]);
    @(posedge clk);
    arst_n <= 1'b1;

    // Unmapped requests pass through untouched.
    for (int i = 0; i < N_UNMAPPED; i++) begin
      a = rand32();
      while (in_window(a, JOY_BASE) || in_window(a, DISP_BASE)) a = rand32();
      d = rand32();
      w = d[19];
      access(w, a, d, ack, data);
      check("unmapped ack", 0, ack);
      check("unmapped data", d, data);
    end

    // Joystick samples. Both channels are valid by the fourth CONVST.
    wait_frames(4);
    read_reg(JOY_BASE + JOY_REG_X, data);
    check("joystick x", adc_vals[0 +: ADC_BITS], data);
    read_reg(JOY_BASE + JOY_REG_Y, data);
    check("joystick y", adc_vals[ADC_BITS +: ADC_BITS], data);
    read_reg(JOY_BASE + JOY_REG_COUNT, cnt0);
    wait_frames(2);
    read_reg(JOY_BASE + JOY_REG_COUNT, cnt1);
    check("sample count step", 2, cnt1 - cnt0);
    new_adc_values();
    wait_frames(3);
    read_reg(JOY_BASE + JOY_REG_X, data);
    check("joystick x after change", adc_vals[0 +: ADC_BITS], data);
    read_reg(JOY_BASE + JOY_REG_Y, data);
    check("joystick y after change", adc_vals[ADC_BITS +: ADC_BITS], data);

    // Display writes in groups that fit the queue.
    for (int g = 0; g < N_DISP / 4; g++) begin
      for (int k = 0; k < 4; k++) begin
        d = rand32();
        write_reg(DISP_BASE + (d[20] ? DISP_REG_DATA : DISP_REG_CMD), d);
        exp_spi.push_back({d[20], d[7:0]});
      end
      drain_display(status);
    end
    compare_spi();

    // Burst. One entry leaves for the idle shifter, then DEPTH more fit.
    for (int i = 0; i < N_BURST; i++) begin
      d = rand32();
      send(1'b1, DISP_BASE + (d[20] ? DISP_REG_DATA : DISP_REG_CMD), d);
      if (i < DISP_FIFO_DEPTH + 1) exp_spi.push_back({d[20], d[7:0]});
    end
    release_bus();
    for (int i = 0; i < N_BURST; i++) begin
      receive(ack, data);
      check("burst ack", 1, ack);
    end
    read_reg(DISP_BASE + DISP_REG_STATUS, status);
    check("status overflow", 1, status[16]);
    drain_display(status);
    check("status after clear", 0, status);
    compare_spi();

    // Read-only joystick registers and unused offsets.
    write_reg(JOY_BASE + JOY_REG_X, rand32());
    write_reg(JOY_BASE + JOY_REG_Y, rand32());
    write_reg(JOY_BASE + JOY_REG_COUNT, rand32());
    read_reg(JOY_BASE + JOY_REG_X, data);
    check("joystick x after write", adc_vals[0 +: ADC_BITS], data);
    read_reg(JOY_BASE + JOY_REG_Y, data);
    check("joystick y after write", adc_vals[ADC_BITS +: ADC_BITS], data);
    for (int i = 0; i < 4; i++) begin
      a = 3 + (rand32() % 29);
      read_reg(JOY_BASE + a, data);
      check("joystick unused offset", 0, data);
      read_reg(DISP_BASE + a, data);
      check("display unused offset", 0, data);
    end

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* tb.f */
design/shield_pkg.sv
design/bus_node.sv
design/adc_sampler.sv
design/joystick.sv
design/spi_tx.sv
design/st7735r.sv
design/shield.sv
sim/tb_models.sv
sim/tb_shield.sv
